/* verilog/pcm_types_pkg.sv */
// data path types; samples are signed 16-bit mono, volume is 9-bit unsigned with 256 as unity
package pcm_types_pkg;

	// one signed PCM sample as it travels from the CPU port to the DAC
	typedef logic signed [15:0] pcm_sample_t;

	// gain in 1/256 steps; 0 mutes, 511 is just under 2x
	typedef logic [8:0] pcm_volume_t;

	localparam pcm_volume_t VOL_UNITY = 9'd256;    // gain of 1.0, reset value

	// single FIFO write, valid for one cycle
	typedef struct packed {
		logic        valid;                        // write strobe
		pcm_sample_t sample;                       // value to store
	} pcm_push_t;

	// one sample toward the DAC
	typedef struct packed {
		logic        strobe;                       // high for one cycle per sample
		pcm_sample_t sample;                       // scaled, held between strobes
	} pcm_audio_t;

endpackage

/* verilog/pcm_regs_pkg.sv */
// CPU register map and player FSM encoding; write-only port, address 3 is ignored
package pcm_regs_pkg;

	// 2-bit register addresses seen on the CPU port
	typedef enum logic [1:0] {
		REG_SAMPLE = 2'd0,                         // push one sample into the FIFO
		REG_VOLUME = 2'd1,                         // low 9 bits are the gain
		REG_CTRL   = 2'd2                          // play enable and overflow clear
	} pcm_reg_e;

	// bit positions inside a REG_CTRL write
	localparam int CTRL_PLAY_BIT    = 0;           // 1 = playback enabled
	localparam int CTRL_CLR_OVF_BIT = 1;           // write 1 to clear overflow

	// playback FSM states
	typedef enum logic [1:0] {
		PLAY_IDLE    = 2'd0,                       // play disabled, output muted
		PLAY_PREFILL = 2'd1,                       // waiting for enough buffered samples
		PLAY_RUN     = 2'd2                        // one pop per sample tick
	} player_state_e;

endpackage

/* verilog/pcm_reg_port.sv */
// write-only CPU port; sample pushes are combinational and not held, so a push into a full FIFO is lost
`timescale 1ns/1ps

module pcm_reg_port (
	input  logic                        i_clk,
	input  logic                        i_rst,
	input  logic                        i_ce,
	input  logic                        i_cpu_we,
	input  pcm_regs_pkg::pcm_reg_e      i_cpu_addr,
	input  logic [15:0]                 i_cpu_wdata,
	input  logic                        i_full,
	output pcm_types_pkg::pcm_push_t    o_push,
	output pcm_types_pkg::pcm_volume_t  o_volume,
	output logic                        o_play_en,
	output logic                        o_overflow
);

	logic wr_en;
	logic wr_sample;
	logic wr_ctrl;
	logic ovf_set;
	logic ovf_clr;

	assign wr_en     = i_ce & i_cpu_we;                                      // strobes on ce-low cycles are lost
	assign wr_sample = wr_en & (i_cpu_addr == pcm_regs_pkg::REG_SAMPLE);
	assign wr_ctrl   = wr_en & (i_cpu_addr == pcm_regs_pkg::REG_CTRL);

	// push goes straight to the FIFO in the write cycle
	assign o_push.valid  = wr_sample;
	assign o_push.sample = pcm_types_pkg::pcm_sample_t'(i_cpu_wdata);

	assign ovf_set = wr_sample & i_full;                                     // FIFO drops this one
	assign ovf_clr = wr_ctrl & i_cpu_wdata[pcm_regs_pkg::CTRL_CLR_OVF_BIT];

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_volume  <= pcm_types_pkg::VOL_UNITY;
			o_play_en <= 1'b0;
		end else if (wr_en) begin
			case (i_cpu_addr)
				pcm_regs_pkg::REG_VOLUME: begin
					o_volume <= i_cpu_wdata[$bits(pcm_types_pkg::pcm_volume_t)-1:0];
				end
				pcm_regs_pkg::REG_CTRL: begin
					o_play_en <= i_cpu_wdata[pcm_regs_pkg::CTRL_PLAY_BIT];
				end
				default: begin
					// samples handled above, address 3 reserved
				end
			endcase
		end
	end

	// sticky overflow, a new drop beats a clear in the same cycle
	always_ff @(posedge i_clk) begin
		if (i_rst)
			o_overflow <= 1'b0;
		else if (ovf_set)
			o_overflow <= 1'b1;
		else if (ovf_clr)
			o_overflow <= 1'b0;
	end

	a_push_needs_ce: assert property (@(posedge i_clk) disable iff (i_rst)
		!i_ce |-> !o_push.valid)
		else $error("push issued while clock enable is low");

endmodule

/* verilog/sample_fifo.sv */
// single clock FIFO with ce; holds 2**DEPTH_WIDTH samples, o_level counts RAM entries only (max 2**DEPTH_WIDTH-1)
`timescale 1ns/1ps

module sample_fifo #(
	parameter int DEPTH_WIDTH = 5
) (
	input  logic                        i_clk,
	input  logic                        i_rst,
	input  logic                        i_ena,
	input  pcm_types_pkg::pcm_push_t    i_push,
	input  logic                        i_r_taken,
	output pcm_types_pkg::pcm_sample_t  o_r_data,
	output logic [DEPTH_WIDTH:0]        o_level,
	output logic                        o_w_full,
	output logic                        o_r_valid
);

	localparam int DEPTH = 2 ** DEPTH_WIDTH;
	localparam logic [DEPTH_WIDTH:0] C_MAX = (DEPTH_WIDTH+1)'(DEPTH - 1);
	localparam logic [DEPTH_WIDTH:0] C_ONE = (DEPTH_WIDTH+1)'(1);
	localparam logic [DEPTH_WIDTH-1:0] C_PTR_INC = DEPTH_WIDTH'(1);

	pcm_types_pkg::pcm_sample_t mem [DEPTH];

	logic [DEPTH_WIDTH-1:0] wr_ptr;
	logic [DEPTH_WIDTH-1:0] rd_ptr;
	logic [DEPTH_WIDTH-1:0] ram_raddr;             // registered read address, points at presented sample
	logic [DEPTH_WIDTH:0]   level_q;
	logic                   full_q;
	logic                   empty_q;
	logic                   fetch_q;               // read address loaded
	logic                   out_valid_q;           // one cycle behind fetch_q
	logic                   w_ena;
	logic                   r_ena;
	logic                   w_ena_g;
	logic                   r_ena_g;
	logic                   near_full;
	logic                   near_empty;

	assign w_ena   = i_push.valid & ~full_q;
	assign r_ena   = (i_r_taken | ~fetch_q) & ~empty_q;  // prefetch whenever output slot frees up
	assign w_ena_g = i_ena & w_ena;
	assign r_ena_g = i_ena & r_ena;

	// look-ahead compares feed the registered flags
	assign near_full  = (level_q == C_MAX - C_ONE);
	assign near_empty = (level_q == C_ONE);

	always_ff @(posedge i_clk) begin
		if (w_ena_g)
			mem[wr_ptr] <= i_push.sample;
		if (r_ena_g)
			ram_raddr <= rd_ptr;
	end

	assign o_r_data = mem[ram_raddr];

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			level_q <= '0;
			full_q  <= 1'b0;
			empty_q <= 1'b1;
		end else if (i_ena) begin
			if (w_ena)
				wr_ptr <= wr_ptr + C_PTR_INC;
			if (r_ena)
				rd_ptr <= rd_ptr + C_PTR_INC;
			case ({w_ena, r_ena})
				2'b10: begin
					level_q <= level_q + C_ONE;
					empty_q <= 1'b0;
					if (near_full)
						full_q <= 1'b1;
				end
				2'b01: begin
					level_q <= level_q - C_ONE;
					full_q  <= 1'b0;
					if (near_empty)
						empty_q <= 1'b1;
				end
				default: begin
					// write and read together leave the level alone
				end
			endcase
		end
	end

	// two-stage valid; stage 2 drops at once when the last sample is taken
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			fetch_q     <= 1'b0;
			out_valid_q <= 1'b0;
		end else if (i_ena) begin
			if (r_ena)
				fetch_q <= 1'b1;
			else if (i_r_taken)
				fetch_q <= 1'b0;
			out_valid_q <= fetch_q & ~(i_r_taken & ~r_ena);
		end
	end

	assign o_w_full  = full_q;
	assign o_r_valid = out_valid_q;
	assign o_level   = level_q;

	a_level_max: assert property (@(posedge i_clk) disable iff (i_rst)
		o_level <= C_MAX)
		else $error("FIFO level above RAM capacity");

	a_taken_valid: assert property (@(posedge i_clk) disable iff (i_rst)
		i_r_taken |-> o_r_valid)
		else $error("sample taken while output not valid");

	if (DEPTH_WIDTH < 1) begin : g_depth_check
		$error("sample_fifo: DEPTH_WIDTH must be at least 1");
	end

endmodule

/* verilog/pcm_player.sv */
// tick-paced playback; tick is a one-cycle strobe, PREFILL_LEVEL must be at most 2**DEPTH_WIDTH-1
`timescale 1ns/1ps

module pcm_player #(
	parameter int DEPTH_WIDTH   = 5,
	parameter int PREFILL_LEVEL = 8
) (
	input  logic                        i_clk,
	input  logic                        i_rst,
	input  logic                        i_ce,
	input  logic                        i_sample_tick,
	input  logic                        i_play_en,
	input  pcm_types_pkg::pcm_volume_t  i_volume,
	input  pcm_types_pkg::pcm_sample_t  i_r_data,
	input  logic                        i_r_valid,
	input  logic [DEPTH_WIDTH:0]        i_level,
	output logic                        o_r_taken,
	output pcm_types_pkg::pcm_audio_t   o_audio,
	output logic                        o_underrun
);

	localparam logic [DEPTH_WIDTH:0] C_PREFILL = (DEPTH_WIDTH+1)'(PREFILL_LEVEL);
	localparam logic signed [17:0]   C_SAT_MAX = 18'sd32767;
	localparam logic signed [17:0]   C_SAT_MIN = -18'sd32768;

	pcm_regs_pkg::player_state_e state_q;
	pcm_regs_pkg::player_state_e state_d;

	logic                       run_tick;
	logic                       take;
	logic                       starve;
	logic                       filled;
	logic signed [25:0]         product;
	logic signed [17:0]         scaled;
	pcm_types_pkg::pcm_sample_t sat_sample;

	assign run_tick  = i_ce & i_sample_tick & i_play_en & (state_q == pcm_regs_pkg::PLAY_RUN);
	assign take      = run_tick & i_r_valid;
	assign starve    = run_tick & ~i_r_valid;       // buffer ran dry
	assign filled    = (i_level >= C_PREFILL);
	assign o_r_taken = take;

	always_comb begin
		state_d = state_q;
		if (!i_play_en) begin
			state_d = pcm_regs_pkg::PLAY_IDLE;
		end else begin
			case (state_q)
				pcm_regs_pkg::PLAY_IDLE:    state_d = pcm_regs_pkg::PLAY_PREFILL;
				pcm_regs_pkg::PLAY_PREFILL: if (filled) state_d = pcm_regs_pkg::PLAY_RUN;
				pcm_regs_pkg::PLAY_RUN:     if (starve) state_d = pcm_regs_pkg::PLAY_PREFILL;
				default:                    state_d = pcm_regs_pkg::PLAY_IDLE;
			endcase
		end
	end

	// gain in 1/256 steps, arithmetic shift rounds toward minus infinity
	assign product = 26'(i_r_data) * 26'($signed({1'b0, i_volume}));
	assign scaled  = product[25:8];

	always_comb begin
		if (scaled > C_SAT_MAX)
			sat_sample = 16'sh7fff;
		else if (scaled < C_SAT_MIN)
			sat_sample = 16'sh8000;
		else
			sat_sample = scaled[15:0];
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state_q    <= pcm_regs_pkg::PLAY_IDLE;
			o_audio    <= '0;
			o_underrun <= 1'b0;
		end else begin
			o_audio.strobe <= take;                 // one cycle after the tick
			o_underrun     <= starve;
			if (i_ce) begin
				state_q <= state_d;
				if (state_q == pcm_regs_pkg::PLAY_IDLE)
					o_audio.sample <= '0;           // muted while stopped
				else if (take)
					o_audio.sample <= sat_sample;   // underrun keeps the last value
			end
		end
	end

	a_strobe_xor_underrun: assert property (@(posedge i_clk) disable iff (i_rst)
		!(o_audio.strobe && o_underrun))
		else $error("strobe and underrun in the same cycle");

	a_take_in_run: assert property (@(posedge i_clk) disable iff (i_rst)
		o_r_taken |-> (state_q == pcm_regs_pkg::PLAY_RUN))
		else $error("FIFO popped outside PLAY_RUN");

	if (PREFILL_LEVEL > (2 ** DEPTH_WIDTH) - 1) begin : g_prefill_check
		$error("pcm_player: PREFILL_LEVEL exceeds the FIFO level range");
	end

endmodule

/* verilog/pcm_stream_top.sv */
// PCM sample path from CPU writes to DAC strobes; single clock i_clk with enable i_ce, mono only
`timescale 1ns/1ps

module pcm_stream_top #(
	parameter int DEPTH_WIDTH   = 5,
	parameter int PREFILL_LEVEL = 8
) (
	input  logic                        i_clk,
	input  logic                        i_rst,
	input  logic                        i_ce,
	input  logic                        i_cpu_we,
	input  pcm_regs_pkg::pcm_reg_e      i_cpu_addr,
	input  logic [15:0]                 i_cpu_wdata,
	input  logic                        i_sample_tick,
	output pcm_types_pkg::pcm_audio_t   o_audio,
	output logic [DEPTH_WIDTH:0]        o_level,
	output logic                        o_full,
	output logic                        o_overflow,
	output logic                        o_underrun
);

	pcm_types_pkg::pcm_push_t   push;
	pcm_types_pkg::pcm_volume_t volume;
	pcm_types_pkg::pcm_sample_t r_data;
	logic                       play_en;
	logic                       r_valid;
	logic                       r_taken;

	pcm_reg_port u_reg_port (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_ce        (i_ce),
		.i_cpu_we    (i_cpu_we),
		.i_cpu_addr  (i_cpu_addr),
		.i_cpu_wdata (i_cpu_wdata),
		.i_full      (o_full),
		.o_push      (push),
		.o_volume    (volume),
		.o_play_en   (play_en),
		.o_overflow  (o_overflow)
	);

	sample_fifo #(
		.DEPTH_WIDTH (DEPTH_WIDTH)
	) u_fifo (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_ena     (i_ce),
		.i_push    (push),
		.i_r_taken (r_taken),
		.o_r_data  (r_data),
		.o_level   (o_level),
		.o_w_full  (o_full),
		.o_r_valid (r_valid)
	);

	pcm_player #(
		.DEPTH_WIDTH   (DEPTH_WIDTH),
		.PREFILL_LEVEL (PREFILL_LEVEL)
	) u_player (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_ce          (i_ce),
		.i_sample_tick (i_sample_tick),
		.i_play_en     (play_en),
		.i_volume      (volume),
		.i_r_data      (r_data),
		.i_r_valid     (r_valid),
		.i_level       (o_level),
		.o_r_taken     (r_taken),
		.o_audio       (o_audio),
		.o_underrun    (o_underrun)
	);

endmodule

/* tests/tb_clock_gen.sv */
// testbench clock and reset; 40 ns period, reset high for RST_CYCLES rising edges, released on a falling edge
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int HALF_PERIOD = 20,
	parameter int RST_CYCLES  = 16
) (
	output logic o_clk,
	output logic o_rst
);

	initial begin
		o_clk = 1'b0;
		forever #(HALF_PERIOD) o_clk = ~o_clk;
	end

	initial begin
		o_rst = 1'b1;
		repeat (RST_CYCLES) @(posedge o_clk);
		@(negedge o_clk);                          // release away from the sampling edge
		o_rst = 1'b0;
	end

endmodule

/* tests/pcm_stream_tb.sv */
// testbench for pcm_stream_top with default parameters; i_ce held high, ticks at least TICK_GAP cycles apart
`timescale 1ns/1ps

module pcm_stream_tb;

	localparam int DEPTH_WIDTH = 5;
	localparam int FIFO_CAP    = 2 ** DEPTH_WIDTH;
	localparam int TICK_GAP    = 6;
	localparam int WAIT_LIMIT  = 200;
	localparam logic [DEPTH_WIDTH:0] LEVEL_MAX = (DEPTH_WIDTH+1)'(FIFO_CAP - 1);
	localparam logic [DEPTH_WIDTH:0] PREFILL   = (DEPTH_WIDTH+1)'(8);

	logic                       clk;
	logic                       rst;
	logic                       ce;
	logic                       cpu_we;
	pcm_regs_pkg::pcm_reg_e     cpu_addr;
	logic [15:0]                cpu_wdata;
	logic                       sample_tick;
	pcm_types_pkg::pcm_audio_t  audio;
	logic [DEPTH_WIDTH:0]       level;
	logic                       full;
	logic                       overflow;
	logic                       underrun;

	// reference model state
	pcm_types_pkg::pcm_sample_t model_q[$];        // samples the FIFO holds
	pcm_types_pkg::pcm_sample_t exp_sample;
	int                         model_vol;
	int                         seed;
	logic                       model_run;         // player expected in PLAY_RUN
	logic                       expect_pop;
	logic                       expect_starve;
	logic                       exp_ovf;
	logic                       exp_full;

	tb_clock_gen u_clk_gen (
		.o_clk (clk),
		.o_rst (rst)
	);

	pcm_stream_top dut0 (
		.i_clk         (clk),
		.i_rst         (rst),
		.i_ce          (ce),
		.i_cpu_we      (cpu_we),
		.i_cpu_addr    (cpu_addr),
		.i_cpu_wdata   (cpu_wdata),
		.i_sample_tick (sample_tick),
		.o_audio       (audio),
		.o_level       (level),
		.o_full        (full),
		.o_overflow    (overflow),
		.o_underrun    (underrun)
	);

	task automatic stop_failed();
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_error(input string msg);
		$display("ERROR at time %0t: %s", $time, msg);
		stop_failed();
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out waiting for %s", what);
		stop_failed();
	endtask

	// gain in 1/256 steps, floor shift, clipped to 16 bits
	function automatic pcm_types_pkg::pcm_sample_t scale_sample(
		input pcm_types_pkg::pcm_sample_t s,
		input int vol
	);
		int prod;
		prod = int'(s) * vol;
		prod = prod >>> 8;
		if (prod > 32767)
			prod = 32767;
		else if (prod < -32768)
			prod = -32768;
		return pcm_types_pkg::pcm_sample_t'(prod);
	endfunction

	task automatic cpu_write(input pcm_regs_pkg::pcm_reg_e addr, input logic [15:0] data);
		cpu_we    = 1'b1;
		cpu_addr  = addr;
		cpu_wdata = data;
		@(negedge clk);
		cpu_we    = 1'b0;
	endtask

	task automatic push_sample();
		pcm_types_pkg::pcm_sample_t s;
		s = pcm_types_pkg::pcm_sample_t'($random(seed));
		if (model_q.size() < FIFO_CAP)
			model_q.push_back(s);
		else
			exp_ovf = 1'b1;                        // dropped, flag goes sticky
		exp_full = (model_q.size() == FIFO_CAP);
		cpu_write(pcm_regs_pkg::REG_SAMPLE, s);
	endtask

	task automatic set_play(input logic en);
		logic [15:0] ctrl;
		ctrl = '0;
		ctrl[pcm_regs_pkg::CTRL_PLAY_BIT] = en;
		if (!en) begin
			model_run  = 1'b0;
			exp_sample = '0;                       // idle mutes the output
		end
		cpu_write(pcm_regs_pkg::REG_CTRL, ctrl);
	endtask

	task automatic clear_overflow();
		logic [15:0] ctrl;
		ctrl = '0;
		ctrl[pcm_regs_pkg::CTRL_CLR_OVF_BIT] = 1'b1;
		exp_ovf = 1'b0;
		cpu_write(pcm_regs_pkg::REG_CTRL, ctrl);
	endtask

	task automatic set_volume(input int vol);
		model_vol = vol;
		cpu_write(pcm_regs_pkg::REG_VOLUME, 16'(vol));
	endtask

	task automatic send_tick();
		if (model_run && model_q.size() > 0) begin
			exp_sample    = scale_sample(model_q.pop_front(), model_vol);
			expect_pop    = 1'b1;
			expect_starve = 1'b0;
		end else begin
			expect_pop    = 1'b0;
			expect_starve = model_run;             // dry buffer in run
			model_run     = 1'b0;
		end
		exp_full    = (model_q.size() == FIFO_CAP);
		sample_tick = 1'b1;
		@(negedge clk);
		sample_tick = 1'b0;
		repeat (TICK_GAP - 1) @(negedge clk);
	endtask

	task automatic drain_fifo();
		int ticks;
		ticks = 0;
		while (model_q.size() > 0) begin
			send_tick();
			ticks++;
			if (ticks > FIFO_CAP)
				report_timeout("the FIFO to drain");
		end
	endtask

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		@(negedge clk);                            // reset is driven from time 0
		while (rst) begin
			@(negedge clk);
			cycles++;
			if (cycles > WAIT_LIMIT)
				report_timeout("reset release");
		end
	endtask

	task automatic wait_prefill();
		int cycles;
		cycles = 0;
		while (level < PREFILL) begin
			@(negedge clk);
			cycles++;
			if (cycles > WAIT_LIMIT)
				report_timeout("FIFO level to reach the prefill level");
		end
		repeat (3) @(negedge clk);                 // player moves to PLAY_RUN
		model_run = 1'b1;
	endtask

	a_reset_state: assert property (@(posedge clk)
		$past(rst) |-> (!audio.strobe && !underrun && !overflow && !full && level == '0))
		else report_error("outputs not in reset state");

	a_strobe_timing: assert property (@(posedge clk) disable iff (rst)
		audio.strobe == $past(sample_tick && expect_pop))
		else report_error("audio strobe missing or unexpected");

	a_underrun_timing: assert property (@(posedge clk) disable iff (rst)
		underrun == $past(sample_tick && expect_starve))
		else report_error("underrun missing or unexpected");

	a_sample_value: assert property (@(posedge clk) disable iff (rst)
		(audio.strobe || underrun) |-> (audio.sample == exp_sample))
		else report_error($sformatf("audio sample %0d, expected %0d",
			audio.sample, exp_sample));

	a_underrun_hold: assert property (@(posedge clk) disable iff (rst)
		underrun |-> $stable(audio.sample))
		else report_error("audio sample changed on underrun");

	a_overflow_flag: assert property (@(posedge clk) disable iff (rst)
		overflow == $past(exp_ovf))
		else report_error("overflow flag does not match dropped writes");

	a_full_flag: assert property (@(posedge clk) disable iff (rst)
		full == $past(exp_full))
		else report_error("full flag does not match FIFO contents");

	a_level_cap: assert property (@(posedge clk) disable iff (rst)
		(level <= LEVEL_MAX) && (!full || level == LEVEL_MAX))
		else report_error($sformatf("level %0d out of range", level));

	initial begin
		seed          = 19;
		model_vol     = 256;
		model_run     = 1'b0;
		expect_pop    = 1'b0;
		expect_starve = 1'b0;
		exp_ovf       = 1'b0;
		exp_full      = 1'b0;
		exp_sample    = '0;
		ce            = 1'b1;
		cpu_we        = 1'b0;
		cpu_addr      = pcm_regs_pkg::REG_SAMPLE;
		cpu_wdata     = '0;
		sample_tick   = 1'b0;

		wait_reset_release();
		repeat (2) @(negedge clk);

		// prefill hold, then first strobe
		set_play(1'b1);
		repeat (5) push_sample();
		repeat (2) send_tick();
		repeat (3) push_sample();                  // level one below prefill
		send_tick();
		push_sample();                             // level reaches prefill
		wait_prefill();
		send_tick();
		repeat (6) push_sample();

		repeat (7) send_tick();                    // unity gain, write order
		set_volume(128);
		repeat (3) send_tick();
		set_volume(0);
		repeat (2) send_tick();
		set_volume(256);
		drain_fifo();

		// underrun, then a fresh prefill
		send_tick();
		send_tick();
		repeat (4) push_sample();
		send_tick();
		repeat (8) push_sample();
		wait_prefill();
		drain_fifo();

		// overflow with play stopped
		set_play(1'b0);
		repeat (3) @(negedge clk);
		repeat (40) push_sample();
		repeat (3) @(negedge clk);
		clear_overflow();
		set_play(1'b1);
		wait_prefill();
		drain_fifo();                              // exactly the first 32 samples
		send_tick();
		set_play(1'b0);
		repeat (4) @(negedge clk);

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

/* build.f */
verilog/pcm_types_pkg.sv
verilog/pcm_regs_pkg.sv
verilog/pcm_reg_port.sv
verilog/sample_fifo.sv
verilog/pcm_player.sv
verilog/pcm_stream_top.sv
tests/tb_clock_gen.sv
tests/pcm_stream_tb.sv

/* run.sh */
#!/bin/sh
# builds the PCM stream testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module pcm_stream_tb -f build.f -o pcm_stream_sim
./obj_dir/pcm_stream_sim 2>&1 | tee sim.log
if grep -q "Simulation failed" sim.log; then
	echo "run failed"
	exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
	echo "run ended without a result"
	exit 1
fi
